// ==== filelist.f ====
+incdir+source
source/settings_pkg.sv
source/sync_fifo.sv
source/cmd_parser.sv
source/cmd_executor.sv
source/bank_arbiter.sv
source/settings_regs.sv
source/settings_ctrl_top.sv
verif/tb_settings_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the settings controller testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_settings_ctrl \
    -Mdir obj_dir -o sim_settings_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_settings_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

echo "simulation ended cleanly"
exit 0

// ==== source/bank_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    req_a,
    input  logic                    req_b,
    input  settings_pkg::bank_req_t bank_req_a,
    input  settings_pkg::bank_req_t bank_req_b,
    output logic                    ack_a,
    output logic                    ack_b,
    output logic [31:0]             rdata,
    output settings_pkg::bank_req_t bank_req,
    output logic                    bank_strobe,
    input  logic [31:0]             bank_rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CAPTURE,
        S_ACK
    } state_t;

    state_t state;
    logic   last_b;
    logic   pick_b;
    logic   granted_req;

    // b wins when alone or when a went last
    assign pick_b      = req_b && (!req_a || !last_b);
    assign bank_req    = pick_b ? bank_req_b : bank_req_a;
    assign bank_strobe = (state == S_IDLE) && (req_a || req_b);
    assign granted_req = last_b ? req_b : req_a;
    assign ack_a       = (state == S_ACK) && !last_b;
    assign ack_b       = (state == S_ACK) && last_b;

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= S_IDLE;
            last_b <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (bank_strobe) begin
                        last_b <= pick_b;
                        state  <= S_CAPTURE;
                    end
                end
                S_CAPTURE: state <= S_ACK;
                S_ACK: begin
                    // hold ack until the granted side drops req
                    if (!granted_req) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_CAPTURE) rdata <= bank_rdata;
    end

    // one ack at a time, and only to a side that was requesting
    assert property (@(posedge clock) disable iff (reset)
        ack_a |-> !ack_b && $past(req_a));
    assert property (@(posedge clock) disable iff (reset)
        ack_b |-> $past(req_b));

endmodule

`default_nettype wire

// ==== source/cmd_executor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "settings_cfg.svh"

module cmd_executor (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [63:0]                time_now,
    input  settings_pkg::command_t     cmd,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    output settings_pkg::bank_req_t    bank_req,
    output logic                       req,
    input  logic                       ack,
    input  logic [31:0]                rdata,
    output settings_pkg::stream_word_t out_word,
    output logic                       out_valid,
    input  logic                       out_ready
);
    import settings_pkg::*;

    // reply states are kept last so out_valid is one compare
    typedef enum logic [3:0] {
        S_LOAD,
        S_WAIT_TIME,
        S_REQUEST,
        S_RELEASE,
        S_REPLY_HDR,
        S_REPLY_TIME_HI,
        S_REPLY_TIME_LO,
        S_REPLY_CMD_HDR,
        S_REPLY_DATA
    } state_t;

    state_t      state;
    command_t    cur;
    logic [63:0] rb_time;
    logic [31:0] rb_data;
    pkt_hdr_t    reply_hdr;
    logic        sent;

    assign sent      = out_valid && out_ready;
    assign cmd_ready = (state == S_LOAD);
    assign req       = (state == S_REQUEST);
    assign out_valid = (state >= S_REPLY_HDR);

    assign bank_req.addr  = cur.hdr.addr[REG_ADDR_W-1:0];
    assign bank_req.write = cur.hdr.poke;
    assign bank_req.wdata = cur.data;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_LOAD;
        end else begin
            case (state)
                S_LOAD: begin
                    if (cmd_valid) state <= cmd.has_time ? S_WAIT_TIME : S_REQUEST;
                end
                S_WAIT_TIME: begin
                    // a late command falls through on the first compare
                    if (time_now >= cur.ticks) state <= S_REQUEST;
                end
                S_REQUEST: begin
                    if (ack) state <= S_RELEASE;
                end
                S_RELEASE: begin
                    if (!ack) state <= S_REPLY_HDR;
                end
                S_REPLY_HDR:     if (sent) state <= S_REPLY_TIME_HI;
                S_REPLY_TIME_HI: if (sent) state <= S_REPLY_TIME_LO;
                S_REPLY_TIME_LO: if (sent) state <= S_REPLY_CMD_HDR;
                S_REPLY_CMD_HDR: if (sent) state <= S_REPLY_DATA;
                S_REPLY_DATA:    if (sent) state <= S_LOAD;
                default:         state <= S_LOAD;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_LOAD && cmd_valid) cur <= cmd;
        if (state == S_REQUEST && ack) begin
            rb_time <= time_now;
            rb_data <= rdata;
        end
    end

    // --------------------------------------------------
    // reply packet
    // --------------------------------------------------
    always_comb begin
        reply_hdr          = '0;
        reply_hdr.length   = 16'(`SETTINGS_REPLY_WORDS - 1);
        reply_hdr.seq      = cur.hdr.seq;
        reply_hdr.ptype    = PKT_TYPE_REPLY;
        // the capture time is always present
        reply_hdr.has_time = 1'b1;
    end

    always_comb begin
        out_word.sof = (state == S_REPLY_HDR);
        out_word.eof = (state == S_REPLY_DATA);
        case (state)
            S_REPLY_HDR:     out_word.data = reply_hdr;
            S_REPLY_TIME_HI: out_word.data = rb_time[63:32];
            S_REPLY_TIME_LO: out_word.data = rb_time[31:0];
            S_REPLY_CMD_HDR: out_word.data = cur.hdr;
            S_REPLY_DATA:    out_word.data = rb_data;
            default:         out_word.data = '0;
        endcase
    end

    assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_word));

endmodule

`default_nettype wire

// ==== source/cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
    input  logic                       clock,
    input  logic                       reset,
    input  settings_pkg::stream_word_t in_word,
    input  logic                       in_valid,
    output logic                       in_ready,
    output settings_pkg::command_t     cmd,
    output logic                       cmd_valid,
    input  logic                       cmd_ready
);
    import settings_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_TICKS_HI,
        S_TICKS_LO,
        S_HDR,
        S_DATA,
        S_SKIP,
        S_STORE
    } state_t;

    state_t   state;
    pkt_hdr_t pkt_hdr;
    logic     take;

    assign pkt_hdr   = pkt_hdr_t'(in_word.data);
    assign take      = in_valid && in_ready;
    assign in_ready  = (state != S_STORE);
    assign cmd_valid = (state == S_STORE);

    // --------------------------------------------------
    // packet walk
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    // stray words outside a packet are dropped here
                    if (take && in_word.sof && !in_word.eof) begin
                        state <= pkt_hdr.has_time ? S_TICKS_HI : S_HDR;
                    end
                end
                S_TICKS_HI: begin
                    if (take) state <= in_word.eof ? S_IDLE : S_TICKS_LO;
                end
                S_TICKS_LO: begin
                    if (take) state <= in_word.eof ? S_IDLE : S_HDR;
                end
                S_HDR: begin
                    // truncated packet, nothing to execute
                    if (take) state <= in_word.eof ? S_IDLE : S_DATA;
                end
                S_DATA: begin
                    if (take) state <= in_word.eof ? S_STORE : S_SKIP;
                end
                S_SKIP: begin
                    if (take && in_word.eof) state <= S_STORE;
                end
                S_STORE: begin
                    if (cmd_ready) state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // command fields
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (take) begin
            case (state)
                S_IDLE: begin
                    cmd.has_time <= pkt_hdr.has_time;
                    cmd.ticks    <= '0;
                end
                S_TICKS_HI: cmd.ticks[63:32] <= in_word.data;
                S_TICKS_LO: cmd.ticks[31:0]  <= in_word.data;
                S_HDR:      cmd.hdr          <= cmd_hdr_t'(in_word.data);
                S_DATA:     cmd.data         <= in_word.data;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/settings_cfg.svh ====
`ifndef SETTINGS_CFG_SVH
`define SETTINGS_CFG_SVH

// command entries buffered per port
`define SETTINGS_FIFO_DEPTH 4

// registers in the shared bank, only the low address bits select one
`define SETTINGS_NUM_REGS 16

// reply packet length in words, header included
`define SETTINGS_REPLY_WORDS 5

`endif

// ==== source/settings_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "settings_cfg.svh"

module settings_ctrl_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [63:0]                time_now,
    input  settings_pkg::stream_word_t in_a,
    input  logic                       in_a_valid,
    output logic                       in_a_ready,
    input  settings_pkg::stream_word_t in_b,
    input  logic                       in_b_valid,
    output logic                       in_b_ready,
    output settings_pkg::stream_word_t out_a,
    output logic                       out_a_valid,
    input  logic                       out_a_ready,
    output settings_pkg::stream_word_t out_b,
    output logic                       out_b_valid,
    input  logic                       out_b_ready
);
    import settings_pkg::*;

    command_t    parsed_a, parsed_b;
    logic        parsed_a_valid, parsed_a_ready;
    logic        parsed_b_valid, parsed_b_ready;
    command_t    queued_a, queued_b;
    logic        queued_a_valid, queued_a_ready;
    logic        queued_b_valid, queued_b_ready;
    bank_req_t   bank_req_a, bank_req_b, bank_req;
    logic        req_a, req_b, ack_a, ack_b;
    logic [31:0] arb_rdata;
    logic        bank_strobe;
    logic [31:0] bank_rdata;

    // --------------------------------------------------
    // port a channel
    // --------------------------------------------------
    cmd_parser parser_a_i (
        .clock(clock), .reset(reset),
        .in_word(in_a), .in_valid(in_a_valid), .in_ready(in_a_ready),
        .cmd(parsed_a), .cmd_valid(parsed_a_valid), .cmd_ready(parsed_a_ready)
    );

    sync_fifo #(.entry_t(command_t), .DEPTH(`SETTINGS_FIFO_DEPTH)) fifo_a_i (
        .clock(clock), .reset(reset),
        .in_entry(parsed_a), .in_valid(parsed_a_valid), .in_ready(parsed_a_ready),
        .out_entry(queued_a), .out_valid(queued_a_valid), .out_ready(queued_a_ready)
    );

    cmd_executor executor_a_i (
        .clock(clock), .reset(reset), .time_now(time_now),
        .cmd(queued_a), .cmd_valid(queued_a_valid), .cmd_ready(queued_a_ready),
        .bank_req(bank_req_a), .req(req_a), .ack(ack_a), .rdata(arb_rdata),
        .out_word(out_a), .out_valid(out_a_valid), .out_ready(out_a_ready)
    );

    // --------------------------------------------------
    // port b channel
    // --------------------------------------------------
    cmd_parser parser_b_i (
        .clock(clock), .reset(reset),
        .in_word(in_b), .in_valid(in_b_valid), .in_ready(in_b_ready),
        .cmd(parsed_b), .cmd_valid(parsed_b_valid), .cmd_ready(parsed_b_ready)
    );

    sync_fifo #(.entry_t(command_t), .DEPTH(`SETTINGS_FIFO_DEPTH)) fifo_b_i (
        .clock(clock), .reset(reset),
        .in_entry(parsed_b), .in_valid(parsed_b_valid), .in_ready(parsed_b_ready),
        .out_entry(queued_b), .out_valid(queued_b_valid), .out_ready(queued_b_ready)
    );

    cmd_executor executor_b_i (
        .clock(clock), .reset(reset), .time_now(time_now),
        .cmd(queued_b), .cmd_valid(queued_b_valid), .cmd_ready(queued_b_ready),
        .bank_req(bank_req_b), .req(req_b), .ack(ack_b), .rdata(arb_rdata),
        .out_word(out_b), .out_valid(out_b_valid), .out_ready(out_b_ready)
    );

    // --------------------------------------------------
    // shared register bank
    // --------------------------------------------------
    bank_arbiter arbiter_i (
        .clock(clock), .reset(reset),
        .req_a(req_a), .req_b(req_b),
        .bank_req_a(bank_req_a), .bank_req_b(bank_req_b),
        .ack_a(ack_a), .ack_b(ack_b), .rdata(arb_rdata),
        .bank_req(bank_req), .bank_strobe(bank_strobe), .bank_rdata(bank_rdata)
    );

    settings_regs regs_i (
        .clock(clock), .reset(reset),
        .bank_req(bank_req), .bank_strobe(bank_strobe), .bank_rdata(bank_rdata)
    );

endmodule

`default_nettype wire

// ==== source/settings_pkg.sv ====
`default_nettype none

`include "settings_cfg.svh"

package settings_pkg;

    localparam int REG_ADDR_W = $clog2(`SETTINGS_NUM_REGS);

    // packet type codes in bits 7:4 of the packet header
    localparam logic [3:0] PKT_TYPE_CMD   = 4'h1;
    localparam logic [3:0] PKT_TYPE_REPLY = 4'h2;

    // one word of a command or reply stream
    typedef struct packed {
        logic        eof;
        logic        sof;
        logic [31:0] data;
    } stream_word_t;

    // first word of every packet
    typedef struct packed {
        logic [15:0] length;
        logic [3:0]  rsvd_hi;
        logic [3:0]  seq;
        logic [3:0]  ptype;
        logic [2:0]  rsvd_lo;
        logic        has_time;
    } pkt_hdr_t;

    typedef struct packed {
        logic [11:0] rsvd_hi;
        logic [3:0]  seq;
        logic [6:0]  rsvd_lo;
        logic        poke;
        logic [7:0]  addr;
    } cmd_hdr_t;

    // one parsed command, the FIFO entry
    typedef struct packed {
        logic [63:0] ticks;
        cmd_hdr_t    hdr;
        logic [31:0] data;
        logic        has_time;
    } command_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic                  write;
        logic [31:0]           wdata;
    } bank_req_t;

endpackage

`default_nettype wire

// ==== source/settings_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "settings_cfg.svh"

module settings_regs (
    input  logic                    clock,
    input  logic                    reset,
    input  settings_pkg::bank_req_t bank_req,
    input  logic                    bank_strobe,
    output logic [31:0]             bank_rdata
);

    logic [31:0] regs [`SETTINGS_NUM_REGS];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `SETTINGS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (bank_strobe && bank_req.write) begin
            regs[bank_req.addr] <= bank_req.wdata;
        end
    end

    // readback shows the value after the access
    always_ff @(posedge clock) begin
        if (bank_strobe) begin
            bank_rdata <= bank_req.write ? bank_req.wdata : regs[bank_req.addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clock,
    input  logic   reset,
    input  entry_t in_entry,
    input  logic   in_valid,
    output logic   in_ready,
    output entry_t out_entry,
    output logic   out_valid,
    input  logic   out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_entry = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    // storage only, entries become visible through count
    always_ff @(posedge clock) begin
        if (push) mem[wr_ptr] <= in_entry;
    end

    // pointers meet only when the buffer is empty or full
    assert property (@(posedge clock) disable iff (reset)
        count <= CNT_W'(DEPTH) &&
        ((wr_ptr == rd_ptr) == (count == '0 || count == CNT_W'(DEPTH))));

endmodule

`default_nettype wire

// ==== verif/tb_settings_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "settings_cfg.svh"

module tb_settings_ctrl;
    import settings_pkg::*;

    localparam int NUM_ROWS = 16;

    // one command packet and how its reply gets drained
    typedef struct packed {
        logic        port;
        logic        has_time;
        logic [31:0] offset;
        logic        poke;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  seq;
        logic [1:0]  extra;
        logic [1:0]  stall;
    } row_t;

    logic         clock = 1'b0;
    logic         reset;
    // starts just below a 32 bit wrap so the high tick word matters
    logic [63:0]  time_now = 64'h0000_0000_ffff_ff80;
    stream_word_t in_w [2];
    logic         in_v [2];
    logic         in_rdy [2];
    stream_word_t out_w [2];
    logic         out_v [2];
    logic         out_rdy [2];

    row_t         rows [NUM_ROWS];
    logic [31:0]  exp_data [NUM_ROWS];
    logic [63:0]  tick_of [NUM_ROWS];
    logic [63:0]  eof_time [NUM_ROWS];
    logic [63:0]  capture [2];
    logic [31:0]  model [`SETTINGS_NUM_REGS];
    int           row_count = 0;
    int           max_offset = 0;
    int           replies = 0;
    int           limit = 0;
    int           cycles = 0;
    int           seed = 9652;

    settings_ctrl_top settings_ctrl_top_i (
        .clock(clock), .reset(reset), .time_now(time_now),
        .in_a(in_w[0]), .in_a_valid(in_v[0]), .in_a_ready(in_rdy[0]),
        .in_b(in_w[1]), .in_b_valid(in_v[1]), .in_b_ready(in_rdy[1]),
        .out_a(out_w[0]), .out_a_valid(out_v[0]), .out_a_ready(out_rdy[0]),
        .out_b(out_w[1]), .out_b_valid(out_v[1]), .out_b_ready(out_rdy[1])
    );

    always #10 clock = ~clock;

    // free running time base, moves with the other inputs
    always @(posedge clock) begin
        #1;
        time_now = time_now + 64'd1;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            stop_run($sformatf("test timed out after %0d cycles, %0d of %0d replies seen",
                cycles, replies, row_count));
        end
    end

    // --------------------------------------------------
    // error reporting
    // --------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        stop_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
    endtask

    // --------------------------------------------------
    // stimulus table and register model
    // --------------------------------------------------
    task automatic add_row(input logic port, input logic has_time, input int offset,
                           input logic poke, input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] seq, input logic [1:0] extra,
                           input logic [1:0] stall);
        row_t row;
        row.port     = port;
        row.has_time = has_time;
        row.offset   = offset;
        row.poke     = poke;
        row.addr     = addr;
        row.data     = data;
        row.seq      = seq;
        row.extra    = extra;
        row.stall    = stall;
        rows[row_count] = row;
        row_count++;
        if (offset > max_offset) max_offset = offset;
    endtask

    // ports a and b use disjoint registers, so table order is each port's order
    task automatic build_expectations();
        logic [3:0] idx;
        for (int i = 0; i < `SETTINGS_NUM_REGS; i++) begin
            model[i] = '0;
        end
        for (int r = 0; r < row_count; r++) begin
            idx = rows[r].addr[3:0];
            if (rows[r].poke) model[idx] = rows[r].data;
            exp_data[r] = model[idx];
        end
    endtask

    function automatic stream_word_t make_word(input logic [31:0] data);
        stream_word_t w;
        w.sof  = 1'b0;
        w.eof  = 1'b0;
        w.data = data;
        return w;
    endfunction

    // --------------------------------------------------
    // stream drivers
    // --------------------------------------------------
    task automatic send_packet(input logic p, input int r);
        row_t         row;
        pkt_hdr_t     hdr;
        cmd_hdr_t     chdr;
        stream_word_t words [8];
        int           n;
        int           i;
        row = rows[r];
        @(posedge clock);
        // read at the edge, where the time base is settled
        tick_of[r] = time_now + {{32{row.offset[31]}}, row.offset};
        hdr = '0;
        hdr.ptype = PKT_TYPE_CMD;
        hdr.has_time = row.has_time;
        chdr = '0;
        chdr.addr = row.addr;
        chdr.poke = row.poke;
        chdr.seq = row.seq;
        n = 0;
        words[n] = make_word(hdr);
        n++;
        if (row.has_time) begin
            words[n] = make_word(tick_of[r][63:32]);
            n++;
            words[n] = make_word(tick_of[r][31:0]);
            n++;
        end
        words[n] = make_word(chdr);
        n++;
        words[n] = make_word(row.data);
        n++;
        for (int j = 0; j < int'(row.extra); j++) begin
            words[n] = make_word(32'hbad0_0000 | 32'(j));
            n++;
        end
        words[0].sof = 1'b1;
        words[n - 1].eof = 1'b1;
        i = 0;
        while (i < n) begin
            if (words[i].eof) eof_time[r] = time_now;
            #1;
            in_w[p] = words[i];
            in_v[p] = 1'b1;
            // parser ready follows its state only and holds until the next edge
            if (in_rdy[p]) i++;
            @(posedge clock);
        end
        #1;
        in_v[p] = 1'b0;
    endtask

    task automatic send_port(input logic p);
        for (int r = 0; r < row_count; r++) begin
            if (rows[r].port != p) continue;
            send_packet(p, r);
        end
    endtask

    // --------------------------------------------------
    // reply monitors
    // --------------------------------------------------
    task automatic check_reply_word(input int r, input int k, input stream_word_t w);
        row_t        row;
        pkt_hdr_t    hdr;
        cmd_hdr_t    echo;
        logic [63:0] floor_time;
        string       tag;
        row = rows[r];
        tag = $sformatf("out_%s row %0d word %0d", row.port ? "b" : "a", r, k);
        assert (w.sof == (k == 0))
            else flag_mismatch({tag, " sof"}, 64'(k == 0), 64'(w.sof));
        assert (w.eof == (k == `SETTINGS_REPLY_WORDS - 1))
            else flag_mismatch({tag, " eof"}, 64'(k == `SETTINGS_REPLY_WORDS - 1), 64'(w.eof));
        case (k)
            0: begin
                hdr = pkt_hdr_t'(w.data);
                assert (hdr.ptype == 4'h2)
                    else flag_mismatch({tag, " type"}, 64'h2, 64'(hdr.ptype));
                assert (hdr.seq == row.seq)
                    else flag_mismatch({tag, " seq"}, 64'(row.seq), 64'(hdr.seq));
                assert (hdr.length == 16'd4)
                    else flag_mismatch({tag, " length"}, 64'd4, 64'(hdr.length));
                // every reply carries its capture time
                assert (hdr.has_time == 1'b1)
                    else flag_mismatch({tag, " has_time"}, 64'd1, 64'(hdr.has_time));
            end
            1: capture[row.port][63:32] = w.data;
            2: begin
                capture[row.port][31:0] = w.data;
                floor_time = row.has_time ? tick_of[r] : eof_time[r];
                assert (capture[row.port] >= floor_time)
                    else stop_run($sformatf("capture time %h on row %0d is earlier than %h",
                        capture[row.port], r, floor_time));
            end
            3: begin
                echo = '0;
                echo.addr = row.addr;
                echo.poke = row.poke;
                echo.seq = row.seq;
                assert (w.data == echo)
                    else flag_mismatch({tag, " cmd header"}, 64'(echo), 64'(w.data));
            end
            default: begin
                assert (w.data == exp_data[r])
                    else flag_mismatch({tag, " readback"}, 64'(exp_data[r]), 64'(w.data));
            end
        endcase
    endtask

    task automatic watch_replies(input logic p);
        stream_word_t w;
        stream_word_t held;
        logic         holding;
        logic [1:0]   roll;
        int           k;
        holding = 1'b0;
        for (int r = 0; r < row_count; r++) begin
            if (rows[r].port != p) continue;
            k = 0;
            while (k < `SETTINGS_REPLY_WORDS) begin
                @(posedge clock);
                #1;
                // higher stall values leave ready low more often
                roll = 2'($random(seed));
                out_rdy[p] = (roll >= rows[r].stall);
                if (out_v[p]) begin
                    w = out_w[p];
                    if (holding) begin
                        assert (w == held)
                            else flag_mismatch($sformatf("held word row %0d", r),
                                64'(held), 64'(w));
                    end
                    if (out_rdy[p]) begin
                        check_reply_word(r, k, w);
                        k++;
                        holding = 1'b0;
                    end else begin
                        held = w;
                        holding = 1'b1;
                    end
                end else begin
                    assert (!holding)
                        else stop_run($sformatf("reply valid dropped while stalled on row %0d", r));
                end
            end
            replies++;
        end
        // the last word transfers on this edge
        @(posedge clock);
        #1;
        out_rdy[p] = 1'b0;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        reset = 1'b1;
        in_w[0] = '0;
        in_w[1] = '0;
        in_v[0] = 1'b0;
        in_v[1] = 1'b0;
        out_rdy[0] = 1'b0;
        out_rdy[1] = 1'b0;

        // port  timed  offset poke  addr   data           seq   extra stall
        add_row(1'b0, 1'b0,   0, 1'b0, 8'h02, 32'h0000_0000, 4'h1, 2'd0, 2'd0);
        add_row(1'b1, 1'b0,   0, 1'b1, 8'h08, 32'h8888_0008, 4'h1, 2'd0, 2'd2);
        add_row(1'b0, 1'b0,   0, 1'b1, 8'h02, 32'ha5a5_0001, 4'h2, 2'd0, 2'd1);
        add_row(1'b1, 1'b0,   0, 1'b0, 8'h08, 32'h0000_0000, 4'h2, 2'd0, 2'd0);
        add_row(1'b0, 1'b0,   0, 1'b0, 8'h02, 32'hffff_dead, 4'h3, 2'd0, 2'd2);
        add_row(1'b1, 1'b1, 100, 1'b1, 8'h0c, 32'h0c0c_0c0c, 4'h3, 2'd0, 2'd1);
        add_row(1'b0, 1'b1,  40, 1'b1, 8'h05, 32'h1234_5678, 4'h4, 2'd0, 2'd0);
        add_row(1'b1, 1'b0,   0, 1'b0, 8'h0f, 32'h0000_0000, 4'h4, 2'd1, 2'd3);
        add_row(1'b0, 1'b0,   0, 1'b0, 8'h15, 32'h0000_0000, 4'h5, 2'd2, 2'd3);
        add_row(1'b1, 1'b1,   0, 1'b0, 8'h0c, 32'h0000_0000, 4'h5, 2'd0, 2'd0);
        add_row(1'b0, 1'b1,  -8, 1'b1, 8'h07, 32'hcafe_0007, 4'h6, 2'd1, 2'd1);
        add_row(1'b1, 1'b0,   0, 1'b1, 8'h3a, 32'h5a5a_a5a5, 4'h6, 2'd2, 2'd2);
        add_row(1'b0, 1'b0,   0, 1'b0, 8'h07, 32'h0000_0000, 4'h7, 2'd0, 2'd2);
        add_row(1'b1, 1'b0,   0, 1'b0, 8'h0a, 32'h0000_0000, 4'h7, 2'd0, 2'd1);
        add_row(1'b0, 1'b0,   0, 1'b1, 8'h00, 32'h0000_00ff, 4'h8, 2'd3, 2'd0);
        add_row(1'b1, 1'b0,   0, 1'b0, 8'h0e, 32'h0000_0000, 4'h8, 2'd0, 2'd0);

        build_expectations();
        limit = row_count * 64 + max_offset;

        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        fork
            send_port(1'b0);
            send_port(1'b1);
            watch_replies(1'b0);
            watch_replies(1'b1);
        join

        @(posedge clock);
        #1;
        if (replies == row_count && !out_v[0] && !out_v[1]) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_run($sformatf("run ended with %0d of %0d replies or a reply still pending",
                replies, row_count));
        end
    end

endmodule

`default_nettype wire
